// ==== hdl/spritePkg.sv ====
package spritePkg;

   // raster, kept small so that a frame simulates quickly
   localparam int hActive  = 64;
   localparam int hFront   = 4;
   localparam int hSyncLen = 8;
   localparam int hBack    = 4;
   localparam int hTotal   = hActive + hFront + hSyncLen + hBack;   // 80 pixel clocks per line

   localparam int vActive  = 48;
   localparam int vFront   = 2;
   localparam int vSyncLen = 2;
   localparam int vBack    = 4;
   localparam int vTotal   = vActive + vFront + vSyncLen + vBack;   // 56 lines per frame

   localparam int hCountW = 7;
   localparam int vCountW = 6;

   // sprite store geometry
   localparam int spriteSize = 16;
   localparam int spriteIdxW = $clog2(spriteSize);   // row or column index bits
   localparam int frameCount = 2;
   localparam int frameW     = 1;
   localparam int romAddrW   = frameW + 2 * spriteIdxW;   // {frame, row, column}

   // Wishbone register map
   localparam int wbAdrW = 3;
   localparam int wbDatW = 16;

   localparam int ctrlEnableBit = 0;
   localparam int ctrlPeriodLsb = 4;
   localparam int ctrlPeriodW   = 4;

   localparam int colourW     = 12;   // 4:4:4 rgb
   localparam int pipeLatency = 2;    // timing counters to video outputs

   typedef logic [hCountW-1:0]     hCountT;
   typedef logic [vCountW-1:0]     vCountT;
   typedef logic [frameW-1:0]      frameT;
   typedef logic [romAddrW-1:0]    romAddrT;
   typedef logic [wbAdrW-1:0]      wbAdrT;
   typedef logic [wbDatW-1:0]      wbDatT;
   typedef logic [ctrlPeriodW-1:0] periodT;
   typedef logic [colourW-1:0]     colourT;

   localparam wbAdrT regX      = wbAdrT'(0);
   localparam wbAdrT regY      = wbAdrT'(1);
   localparam wbAdrT regCtrl   = wbAdrT'(2);
   localparam wbAdrT regColour = wbAdrT'(3);
   localparam wbAdrT regStatus = wbAdrT'(4);   // read only, current animation frame

   localparam colourT bgColour = '0;

endpackage

// ==== hdl/videoTiming.sv ====
`timescale 1ns/10ps

module videoTiming (
   input  logic              clk,
   input  logic              rstN,
   output spritePkg::hCountT hCount,
   output spritePkg::vCountT vCount,
   output logic              active,
   output logic              hSync,
   output logic              vSync,
   output logic              frameStart
);

   spritePkg::hCountT hNext;
   spritePkg::vCountT vNext;
   logic              hLast;
   logic              vLast;
   logic              activeNext;
   logic              hSyncNext;
   logic              vSyncNext;

   assign hLast = (int'(hCount) == spritePkg::hTotal - 1);
   assign vLast = (int'(vCount) == spritePkg::vTotal - 1);

   // every flag is decoded from the next count so it lines up with the registered counters
   always_comb begin
      hNext = hLast ? '0 : hCount + 1'b1;
      vNext = vCount;
      if (hLast) begin
         vNext = vLast ? '0 : vCount + 1'b1;
      end
      activeNext = (int'(hNext) < spritePkg::hActive) && (int'(vNext) < spritePkg::vActive);
      hSyncNext  = !((int'(hNext) >= spritePkg::hActive + spritePkg::hFront) &&
                     (int'(hNext) <  spritePkg::hActive + spritePkg::hFront + spritePkg::hSyncLen));
      vSyncNext  = !((int'(vNext) >= spritePkg::vActive + spritePkg::vFront) &&
                     (int'(vNext) <  spritePkg::vActive + spritePkg::vFront + spritePkg::vSyncLen));
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         hCount     <= spritePkg::hCountT'(spritePkg::hTotal - 1);   // first edge wraps to 0,0
         vCount     <= spritePkg::vCountT'(spritePkg::vTotal - 1);
         active     <= 1'b0;
         hSync      <= 1'b1;   // syncs are active low
         vSync      <= 1'b1;
         frameStart <= 1'b0;
      end else begin
         hCount     <= hNext;
         vCount     <= vNext;
         active     <= activeNext;
         hSync      <= hSyncNext;
         vSync      <= vSyncNext;
         frameStart <= (hNext == '0) && (vNext == '0);
      end
   end

endmodule

// ==== hdl/spriteFrameRom.sv ====
`timescale 1ns/10ps

module spriteFrameRom (
   input  logic               clk,
   input  logic               rstN,
   input  spritePkg::romAddrT addr,
   output logic               pixelBit
);

   // one 16-bit word per sprite row, frames stacked one after another
   logic [spritePkg::spriteSize-1:0] rows [spritePkg::frameCount * spritePkg::spriteSize];
   logic [spritePkg::romAddrW-spritePkg::spriteIdxW-1:0] rowSel;   // {frame, row}
   logic [spritePkg::spriteIdxW-1:0]                     colSel;

   initial begin
      $readmemh("frames.hex", rows);
   end

   assign rowSel = addr[spritePkg::romAddrW-1:spritePkg::spriteIdxW];
   assign colSel = addr[spritePkg::spriteIdxW-1:0];

   // column 0 is the leftmost pixel, held in the msb of the row word
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pixelBit <= 1'b0;   // output latch cleared like a block ram set/reset
      end else begin
         pixelBit <= rows[rowSel][~colSel];
      end
   end

endmodule

// ==== hdl/animSequencer.sv ====
`timescale 1ns/10ps

module animSequencer (
   input  logic              clk,
   input  logic              rstN,
   input  logic              frameStart,
   input  spritePkg::periodT period,
   output spritePkg::frameT  frameIndex
);

   spritePkg::periodT frameCnt;   // video frames shown with the current image
   spritePkg::periodT cntNext;
   spritePkg::frameT  indexQ;
   spritePkg::frameT  indexNext;
   logic              step;

   assign cntNext   = frameCnt + 1'b1;
   assign step      = frameStart && (period != '0) && (cntNext >= period);
   assign indexNext = (int'(indexQ) == spritePkg::frameCount - 1) ? '0 : indexQ + 1'b1;

   // new index is already visible during the frame start cycle itself,
   // so the first pixel of the frame is drawn from it
   assign frameIndex = step ? indexNext : indexQ;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         frameCnt <= '0;
         indexQ   <= '0;
      end else if (frameStart) begin
         if (step) begin
            frameCnt <= '0;
            indexQ   <= indexNext;
         end else if (period == '0) begin
            frameCnt <= '0;   // zero period freezes the animation
         end else begin
            frameCnt <= cntNext;
         end
      end
   end

endmodule

// ==== hdl/spriteRegs.sv ====
`timescale 1ns/10ps

module spriteRegs (
   input  logic              clk,
   input  logic              rstN,
   input  logic              wbCyc,
   input  logic              wbStb,
   input  logic              wbWe,
   input  spritePkg::wbAdrT  wbAdr,
   input  spritePkg::wbDatT  wbDatW,
   output spritePkg::wbDatT  wbDatR,
   output logic              wbAck,
   input  logic              frameStart,
   input  spritePkg::frameT  frameIndex,
   output spritePkg::hCountT spriteX,
   output spritePkg::vCountT spriteY,
   output logic              enable,
   output spritePkg::periodT period,
   output spritePkg::colourT colour
);

   spritePkg::hCountT xShadow;
   spritePkg::hCountT xLive;
   spritePkg::vCountT yShadow;
   spritePkg::vCountT yLive;
   logic              enShadow;
   logic              enLive;
   spritePkg::periodT periodShadow;
   spritePkg::periodT periodLive;
   spritePkg::colourT colourShadow;
   spritePkg::colourT colourLive;
   spritePkg::wbDatT  readData;
   logic              access;

   assign access = wbCyc && wbStb && !wbAck;   // one ack per request

   always_comb begin
      readData = '0;
      case (wbAdr)
         spritePkg::regX:      readData = spritePkg::wbDatT'(xShadow);
         spritePkg::regY:      readData = spritePkg::wbDatT'(yShadow);
         spritePkg::regCtrl: begin
            readData[spritePkg::ctrlEnableBit] = enShadow;
            readData[spritePkg::ctrlPeriodLsb +: spritePkg::ctrlPeriodW] = periodShadow;
         end
         spritePkg::regColour: readData = spritePkg::wbDatT'(colourShadow);
         spritePkg::regStatus: readData = spritePkg::wbDatT'(frameIndex);
         default:              readData = '0;   // unmapped reads zero
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         wbAck        <= 1'b0;
         xShadow      <= '0;
         yShadow      <= '0;
         enShadow     <= 1'b0;
         periodShadow <= '0;
         colourShadow <= '0;
      end else begin
         wbAck <= access;
         if (access && wbWe) begin
            case (wbAdr)
               spritePkg::regX:      xShadow <= wbDatW[spritePkg::hCountW-1:0];
               spritePkg::regY:      yShadow <= wbDatW[spritePkg::vCountW-1:0];
               spritePkg::regCtrl: begin
                  enShadow     <= wbDatW[spritePkg::ctrlEnableBit];
                  periodShadow <= wbDatW[spritePkg::ctrlPeriodLsb +: spritePkg::ctrlPeriodW];
               end
               spritePkg::regColour: colourShadow <= wbDatW[spritePkg::colourW-1:0];
               default:              ;   // status and unmapped ignore writes
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         wbDatR <= readData;   // valid together with the ack
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         xLive      <= '0;
         yLive      <= '0;
         enLive     <= 1'b0;
         periodLive <= '0;
         colourLive <= '0;
      end else if (frameStart) begin
         xLive      <= xShadow;
         yLive      <= yShadow;
         enLive     <= enShadow;
         periodLive <= periodShadow;
         colourLive <= colourShadow;
      end
   end

   // shadows pass straight through during frame start so pixel 0,0 already uses them
   assign spriteX = frameStart ? xShadow      : xLive;
   assign spriteY = frameStart ? yShadow      : yLive;
   assign period  = frameStart ? periodShadow : periodLive;
   assign enable  = enLive;       // used one stage later, live by then
   assign colour  = colourLive;

endmodule

// ==== hdl/spriteRenderer.sv ====
`timescale 1ns/10ps

module spriteRenderer (
   input  logic              clk,
   input  logic              rstN,
   input  spritePkg::hCountT hCount,
   input  spritePkg::vCountT vCount,
   input  logic              active,
   input  logic              hSyncIn,
   input  logic              vSyncIn,
   input  spritePkg::hCountT spriteX,
   input  spritePkg::vCountT spriteY,
   input  logic              enable,
   input  spritePkg::colourT colour,
   input  spritePkg::frameT  frameIndex,
   output spritePkg::colourT pixel,
   output logic              de,
   output logic              hSync,
   output logic              vSync
);

   spritePkg::hCountT  dx;   // offset from the sprite origin, wraps when left of it
   spritePkg::vCountT  dy;
   logic               inX;
   logic               inY;
   spritePkg::romAddrT romAddr;
   logic               romBit;
   logic               hitQ;
   logic               activeQ;
   logic               hSyncQ;
   logic               vSyncQ;

   assign dx  = hCount - spriteX;
   assign dy  = vCount - spriteY;
   assign inX = (hCount >= spriteX) && (int'(dx) < spritePkg::spriteSize);
   assign inY = (vCount >= spriteY) && (int'(dy) < spritePkg::spriteSize);

   assign romAddr = {frameIndex, dy[spritePkg::spriteIdxW-1:0], dx[spritePkg::spriteIdxW-1:0]};

   // address register of stage 1 is the rom's own read register
   spriteFrameRom frameRom (
      .clk      (clk),
      .rstN     (rstN),
      .addr     (romAddr),
      .pixelBit (romBit)
   );

   // stage 1, alongside the rom read
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         hitQ    <= 1'b0;
         activeQ <= 1'b0;
         hSyncQ  <= 1'b1;
         vSyncQ  <= 1'b1;
      end else begin
         hitQ    <= active && inX && inY;
         activeQ <= active;
         hSyncQ  <= hSyncIn;
         vSyncQ  <= vSyncIn;
      end
   end

   // stage 2, colour choice
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pixel <= spritePkg::bgColour;
         de    <= 1'b0;
         hSync <= 1'b1;
         vSync <= 1'b1;
      end else begin
         pixel <= (hitQ && enable && romBit) ? colour : spritePkg::bgColour;
         de    <= activeQ;
         hSync <= hSyncQ;
         vSync <= vSyncQ;
      end
   end

endmodule

// ==== hdl/spriteDisplay.sv ====
`timescale 1ns/10ps

module spriteDisplay (
   input  logic              clk,
   input  logic              rstN,
   input  logic              wbCyc,
   input  logic              wbStb,
   input  logic              wbWe,
   input  spritePkg::wbAdrT  wbAdr,
   input  spritePkg::wbDatT  wbDatW,
   output spritePkg::wbDatT  wbDatR,
   output logic              wbAck,
   output spritePkg::colourT pixel,
   output logic              de,
   output logic              hSync,
   output logic              vSync
);

   spritePkg::hCountT hCount;
   spritePkg::vCountT vCount;
   logic              active;
   logic              hSyncRaw;   // sync straight from the counters, before the pipeline
   logic              vSyncRaw;
   logic              frameStart;
   spritePkg::hCountT spriteX;
   spritePkg::vCountT spriteY;
   logic              enable;
   spritePkg::periodT period;
   spritePkg::colourT colour;
   spritePkg::frameT  frameIndex;

   videoTiming timing (
      .clk        (clk),
      .rstN       (rstN),
      .hCount     (hCount),
      .vCount     (vCount),
      .active     (active),
      .hSync      (hSyncRaw),
      .vSync      (vSyncRaw),
      .frameStart (frameStart)
   );

   spriteRegs regs (
      .clk        (clk),
      .rstN       (rstN),
      .wbCyc      (wbCyc),
      .wbStb      (wbStb),
      .wbWe       (wbWe),
      .wbAdr      (wbAdr),
      .wbDatW     (wbDatW),
      .wbDatR     (wbDatR),
      .wbAck      (wbAck),
      .frameStart (frameStart),
      .frameIndex (frameIndex),
      .spriteX    (spriteX),
      .spriteY    (spriteY),
      .enable     (enable),
      .period     (period),
      .colour     (colour)
   );

   animSequencer sequencer (
      .clk        (clk),
      .rstN       (rstN),
      .frameStart (frameStart),
      .period     (period),
      .frameIndex (frameIndex)
   );

   spriteRenderer renderer (
      .clk        (clk),
      .rstN       (rstN),
      .hCount     (hCount),
      .vCount     (vCount),
      .active     (active),
      .hSyncIn    (hSyncRaw),
      .vSyncIn    (vSyncRaw),
      .spriteX    (spriteX),
      .spriteY    (spriteY),
      .enable     (enable),
      .colour     (colour),
      .frameIndex (frameIndex),
      .pixel      (pixel),
      .de         (de),
      .hSync      (hSync),
      .vSync      (vSync)
   );

endmodule

// ==== bench/spriteDisplayTb.sv ====
`timescale 1ns/10ps

module spriteDisplayTb;

   localparam int frameCycles = spritePkg::hTotal * spritePkg::vTotal;
   localparam int cycleLimit  = 14 * frameCycles + 2000;   // all tests plus margin
   localparam int rowsTotal   = spritePkg::frameCount * spritePkg::spriteSize;
   localparam int rowAddrW    = $clog2(rowsTotal);

   logic              clk;
   logic              rstN;
   logic              wbCyc;
   logic              wbStb;
   logic              wbWe;
   spritePkg::wbAdrT  wbAdr;
   spritePkg::wbDatT  wbDatW;
   spritePkg::wbDatT  wbDatR;
   logic              wbAck;
   spritePkg::colourT pixel;
   logic              de;
   logic              hSync;
   logic              vSync;

   logic [spritePkg::spriteSize-1:0] romModel [rowsTotal];   // reference image
   logic [31:0] rng = 32'd57599;
   int shX = 0;   // shadow registers as the bus wrote them
   int shY = 0;
   int shEn = 0;
   int shPer = 0;
   int shCol = 0;
   int lvX = 0;   // values in force for the current frame
   int lvY = 0;
   int lvEn = 0;
   int lvPer = 0;
   int lvCol = 0;
   int animCnt = 0;
   int animIdx = 0;
   int checks = 0;
   int errors = 0;
   int cycles = 0;
   int frameNum = 0;   // vSync falling edges seen
   int deCount = 0;    // de cycles since the last vSync fall
   int lineDe = 0;
   int lineCount = 0;
   int nonBgSeen = 0;
   int lastHFall = -1;
   int lastVFall = -1;
   logic tracking = 1'b0;
   logic prevH = 1'b1;
   logic prevV = 1'b1;
   logic prevDe = 1'b0;

   spriteDisplay DUT (
      .clk    (clk),
      .rstN   (rstN),
      .wbCyc  (wbCyc),
      .wbStb  (wbStb),
      .wbWe   (wbWe),
      .wbAdr  (wbAdr),
      .wbDatW (wbDatW),
      .wbDatR (wbDatR),
      .wbAck  (wbAck),
      .pixel  (pixel),
      .de     (de),
      .hSync  (hSync),
      .vSync  (vSync)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic int expectedPixel(input int x, input int y);
      int dx;
      int dy;
      logic [31:0] rowAddr;
      dx = x - lvX;
      dy = y - lvY;
      if (lvEn == 0 || dx < 0 || dy < 0 ||
          dx >= spritePkg::spriteSize || dy >= spritePkg::spriteSize) begin
         return int'(spritePkg::bgColour);
      end
      rowAddr = animIdx * spritePkg::spriteSize + dy;
      // leftmost pixel sits in the msb of the row word
      if (((romModel[rowAddr[rowAddrW-1:0]] >> (spritePkg::spriteSize - 1 - dx)) & 1) != 0) begin
         return lvCol;
      end
      return int'(spritePkg::bgColour);
   endfunction

   function automatic int expectedRead(input spritePkg::wbAdrT adr);
      case (adr)
         spritePkg::regX:      return shX;
         spritePkg::regY:      return shY;
         spritePkg::regCtrl:
            return (shEn << spritePkg::ctrlEnableBit) | (shPer << spritePkg::ctrlPeriodLsb);
         spritePkg::regColour: return shCol;
         spritePkg::regStatus: return animIdx;
         default:              return 0;
      endcase
   endfunction

   task automatic applyWrite(input spritePkg::wbAdrT adr, input int dat);
      case (adr)
         spritePkg::regX:      shX = dat & ((1 << spritePkg::hCountW) - 1);
         spritePkg::regY:      shY = dat & ((1 << spritePkg::vCountW) - 1);
         spritePkg::regCtrl: begin
            shEn  = (dat >> spritePkg::ctrlEnableBit) & 1;
            shPer = (dat >> spritePkg::ctrlPeriodLsb) & ((1 << spritePkg::ctrlPeriodW) - 1);
         end
         spritePkg::regColour: shCol = dat & ((1 << spritePkg::colourW) - 1);
         default:              ;
      endcase
   endtask

   // model of the frame start copy and the animation step
   task automatic startFrame();
      lvX   = shX;
      lvY   = shY;
      lvEn  = shEn;
      lvPer = shPer;
      lvCol = shCol;
      if (lvPer == 0) begin
         animCnt = 0;
      end else if (animCnt + 1 >= lvPer) begin
         animCnt = 0;
         animIdx = (animIdx + 1) % spritePkg::frameCount;
      end else begin
         animCnt++;
      end
   endtask

   task automatic checkEq(input int actual, input int expected, input string what);
      checks++;
      if (actual != expected) begin
         errors++;
         $display("[FAIL] %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual, expected);
      end
   endtask

   task automatic stepClk();
      @(posedge clk);
      #1;
   endtask

   task automatic busCycle(input logic we, input spritePkg::wbAdrT adr,
                           input spritePkg::wbDatT wdat, output spritePkg::wbDatT rdat);
      int waited;
      wbCyc  = 1'b1;
      wbStb  = 1'b1;
      wbWe   = we;
      wbAdr  = adr;
      wbDatW = wdat;
      waited = 0;
      stepClk();
      while (!wbAck && waited < 3) begin
         stepClk();
         waited++;
      end
      rdat = wbDatR;
      if (!wbAck) begin
         errors++;
         $display("bus error: register %0d gave no ack within 4 cycles", adr);
      end else if (we) begin
         applyWrite(adr, int'(wdat));
      end
      wbCyc = 1'b0;
      wbStb = 1'b0;
      wbWe  = 1'b0;
      stepClk();   // idle cycle while the ack drops
   endtask

   task automatic wbWrite(input spritePkg::wbAdrT adr, input spritePkg::wbDatT dat);
      spritePkg::wbDatT unused;
      busCycle(1'b1, adr, dat, unused);
   endtask

   task automatic wbRead(input spritePkg::wbAdrT adr, output spritePkg::wbDatT dat);
      busCycle(1'b0, adr, '0, dat);
   endtask

   task automatic waitFrames(input int n);
      int target;
      target = frameNum + n;
      while (frameNum < target) begin
         stepClk();
      end
   endtask

   task automatic waitPixels(input int n);
      while (deCount < n) begin
         stepClk();
      end
   endtask

   task automatic report(input int num, input string name, input int mark);
      if (errors == mark) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: %0d errors", num, name, errors - mark);
      end
   endtask

   // raster and image monitor, outputs sampled mid cycle
   always @(negedge clk) begin
      cycles++;
      if (cycles > cycleLimit) begin
         $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
         $display("Checks failed");
         $finish;
      end else if (rstN) begin
         if (prevH && !hSync) begin
            if (lastHFall >= 0) begin
               checkEq(cycles - lastHFall, spritePkg::hTotal, "hSync period");
            end
            lastHFall = cycles;
         end
         if (prevV && !vSync) begin
            if (lastVFall >= 0) begin
               checkEq(cycles - lastVFall, frameCycles, "vSync period");
            end
            if (tracking) begin
               checkEq(lineCount, spritePkg::vActive, "lines per frame");
            end
            lastVFall = cycles;
            tracking  = 1'b1;
            deCount   = 0;
            lineDe    = 0;
            lineCount = 0;
            frameNum++;
         end
         if (de && tracking) begin
            if (deCount == 0) begin
               startFrame();
            end
            checkEq(int'(pixel),
                    expectedPixel(deCount % spritePkg::hActive, deCount / spritePkg::hActive),
                    $sformatf("pixel %0d,%0d", deCount % spritePkg::hActive,
                              deCount / spritePkg::hActive));
            if (pixel != spritePkg::bgColour) begin
               nonBgSeen++;
            end
            deCount++;
            lineDe++;
         end
         if (prevDe && !de && tracking) begin
            checkEq(lineDe, spritePkg::hActive, "de cycles per line");
            lineDe = 0;
            lineCount++;
         end
         prevH  = hSync;
         prevV  = vSync;
         prevDe = de;
      end
   end

   initial begin
      spritePkg::wbDatT rdat;
      int mark;
      int seenMark;
      int i;
      int p;
      int idx0;
      $readmemh("frames.hex", romModel);
      rstN   = 1'b0;
      wbCyc  = 1'b0;
      wbStb  = 1'b0;
      wbWe   = 1'b0;
      wbAdr  = '0;
      wbDatW = '0;
      repeat (10) @(posedge clk);
      #1;
      rstN = 1'b1;

      mark = errors;
      for (i = 0; i < 4; i++) begin
         rng = xorshift(rng);
         wbWrite(spritePkg::wbAdrT'(i), rng[15:0]);
      end
      for (i = 0; i < 5; i++) begin
         wbRead(spritePkg::wbAdrT'(i), rdat);
         checkEq(int'(rdat), expectedRead(spritePkg::wbAdrT'(i)), "register readback");
      end
      rng = xorshift(rng);
      wbRead(spritePkg::wbAdrT'(32'd5 + rng % 32'd3), rdat);
      checkEq(int'(rdat), 0, "unmapped read");
      wbWrite(spritePkg::regCtrl, 16'h0000);   // still frame 0, so the random period never runs
      report(1, "register readback", mark);

      mark = errors;
      waitFrames(2);
      report(2, "raster timing", mark);

      mark = errors;
      seenMark = nonBgSeen;
      rng = xorshift(rng);
      wbWrite(spritePkg::regX, spritePkg::wbDatT'(rng % 32'd49));   // sprite stays on screen
      rng = xorshift(rng);
      wbWrite(spritePkg::regY, spritePkg::wbDatT'(rng % 32'd33));
      wbWrite(spritePkg::regCtrl, 16'h0001);
      rng = xorshift(rng);
      wbWrite(spritePkg::regColour, spritePkg::wbDatT'(rng[11:0] | 12'h001));
      waitFrames(2);
      checkEq(int'(nonBgSeen > seenMark), 1, "sprite visible");
      report(3, "sprite image", mark);

      mark = errors;
      waitPixels(spritePkg::hActive * (lvY + 8));   // halfway down the sprite
      rng = xorshift(rng);
      wbWrite(spritePkg::regX, spritePkg::wbDatT'((lvX + 1 + int'(rng % 32'd48)) % 49));
      rng = xorshift(rng);
      wbWrite(spritePkg::regColour, spritePkg::wbDatT'(shCol ^ int'(rng[11:0] | 12'h001)));
      waitFrames(2);
      report(4, "mid frame write", mark);

      mark = errors;
      wbRead(spritePkg::regStatus, rdat);
      idx0 = int'(rdat);
      rng = xorshift(rng);
      p = 1 + int'(rng % 32'd3);
      wbWrite(spritePkg::regCtrl, spritePkg::wbDatT'(1 + (p << spritePkg::ctrlPeriodLsb)));
      for (i = 1; i <= 2 * p; i++) begin
         waitPixels(spritePkg::hActive * spritePkg::vActive / 2);
         wbRead(spritePkg::regStatus, rdat);
         checkEq(int'(rdat), (idx0 + i / p) % spritePkg::frameCount, "animation frame index");
         checkEq(animIdx, int'(rdat), "image frame against status");
         waitFrames(1);
      end
      report(5, "animation", mark);

      mark = errors;
      seenMark = nonBgSeen;
      wbWrite(spritePkg::regCtrl, 16'h0000);
      waitFrames(1);
      checkEq(nonBgSeen - seenMark, 0, "lit pixels with sprite disabled");
      report(6, "sprite disabled", mark);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== frames.hex ====
// one sprite row per line, 16 bits, msb is the leftmost pixel
// lines 1 to 16 are frame 0, lines 17 to 32 are frame 1
8000
0100
0180
01C0
FFE0
FFF0
FFF8
FFFC
FFFC
FFF8
FFF0
FFE0
01C0
0180
0100
0000
0000
0080
0180
0380
07FF
0FFF
1FFF
3FFF
3FFF
1FFF
0FFF
07FF
0380
0180
0080
0001

// ==== spriteDisplay.f ====
hdl/spritePkg.sv
hdl/videoTiming.sv
hdl/spriteFrameRom.sv
hdl/animSequencer.sv
hdl/spriteRegs.sv
hdl/spriteRenderer.sv
hdl/spriteDisplay.sv
bench/spriteDisplayTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
   --top-module spriteDisplayTb \
   -f spriteDisplay.f \
   -o spriteSim

./obj_dir/spriteSim | tee sim.log

if grep -q "Checks failed" sim.log; then
   echo "simulation reported failures"
   exit 1
fi
echo "simulation passed"
